//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_datapath
FILELIST = datapath.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim passed" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- datapath.f
+incdir+tests
design/rv32i_pkg.sv
design/control.sv
design/regfile.sv
design/execute_unit.sv
design/load_store_align.sv
design/datapath.sv
tests/tb_datapath.sv

//--- design/control.sv
`timescale 1ns/1ps

module control import rv32i_pkg::*; (
    input  rv32i_word  inst,
    output ctrl_word_t cw
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_reg;
    logic       funct7_ok;
    logic       arith_ok;
    alu_op_t    arith_op;
    rv32i_word  imm_i;
    rv32i_word  imm_s;
    rv32i_word  imm_b;
    rv32i_word  imm_u;
    rv32i_word  imm_j;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    // bit 5 separates op_reg from op_imm
    assign is_reg = inst[5];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // only sub and sra may carry funct7 0100000
    assign funct7_ok = (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 &&
                        (funct3 == 3'b101 || (is_reg && funct3 == 3'b000)));
    assign arith_ok = is_reg ? funct7_ok :
                      ((funct3 == 3'b001 || funct3 == 3'b101) ? funct7_ok : 1'b1);

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg && inst[30]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = inst[30] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        cw = CTRL_BUBBLE;
        cw.opcode = rv_opcode_t'(inst[6:0]);
        cw.src1 = inst[19:15];
        cw.src2 = inst[24:20];
        cw.dest = inst[11:7];
        case (inst[6:0])
            op_lui: begin
                cw.wbmux_sel = wb_u_imm;
                cw.imm = imm_u;
                cw.load_regfile = 1'b1;
            end
            op_auipc: begin
                cw.alumux1_sel = alumux1_pc;
                cw.imm = imm_u;
                cw.load_regfile = 1'b1;
            end
            op_jal: begin
                cw.alumux1_sel = alumux1_pc;
                cw.wbmux_sel = wb_pc_plus4;
                cw.imm = imm_j;
                cw.load_regfile = 1'b1;
            end
            op_jalr: begin
                cw.wbmux_sel = wb_pc_plus4;
                cw.imm = imm_i;
                cw.load_regfile = 1'b1;
                if (funct3 != 3'b000)
                    cw = CTRL_BUBBLE;
            end
            op_br: begin
                // alu forms the target while the comparator decides
                cw.alumux1_sel = alumux1_pc;
                cw.cmp_op = cmp_op_t'(funct3);
                cw.imm = imm_b;
                if (funct3 == 3'b010 || funct3 == 3'b011)
                    cw = CTRL_BUBBLE;
            end
            op_load: begin
                cw.funct3 = funct3;
                cw.wbmux_sel = wb_load;
                cw.imm = imm_i;
                cw.mem_read = 1'b1;
                cw.load_regfile = 1'b1;
                if (funct3 == 3'b011 || funct3[2:1] == 2'b11)
                    cw = CTRL_BUBBLE;
            end
            op_store: begin
                cw.funct3 = funct3;
                cw.imm = imm_s;
                cw.mem_write = 1'b1;
                if (funct3[2] || funct3 == 3'b011)
                    cw = CTRL_BUBBLE;
            end
            op_imm, op_reg: begin
                cw.alu_op = arith_op;
                cw.alumux2_sel = is_reg ? alumux2_rs2 : alumux2_imm;
                cw.cmpmux_sel = is_reg ? cmpmux_rs2 : cmpmux_imm;
                cw.imm = imm_i;
                cw.load_regfile = 1'b1;
                // set-less-than goes through the comparator
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    cw.cmp_op = (funct3 == 3'b010) ? cmp_blt : cmp_bltu;
                    cw.wbmux_sel = wb_cmp;
                end
                if (!arith_ok)
                    cw = CTRL_BUBBLE;
            end
            default: cw = CTRL_BUBBLE;
        endcase
        if (cw.dest == 5'd0)
            cw.load_regfile = 1'b0;
    end

endmodule

//--- design/datapath.sv
`timescale 1ns/1ps

module datapath import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_pipeline,
    input  rv32i_word  inst,
    input  rv32i_word  mem_rdata,
    output rv32i_word  inst_addr,
    output rv32i_word  mem_address,
    output rv32i_word  mem_wdata,
    output logic [3:0] mem_byte_enable,
    output logic       dread,
    output logic       dwrite
);

    rv32i_word  pc;
    ifid_t      ifid;
    idex_t      idex;
    exmem_t     exmem;
    memwb_t     memwb;

    ctrl_word_t dec_cw;
    rv32i_word  reg_a;
    rv32i_word  reg_b;
    rv32i_word  alu_out;
    logic       cmp_bit;
    logic       redirect;
    rv32i_word  redirect_target;
    logic [3:0] store_be;
    rv32i_word  load_value;
    rv32i_word  wb_value;

    // fetch
    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (load_pipeline)
            pc <= redirect ? redirect_target : pc + 32'd4;
    end

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifid <= '{pc: RESET_PC, inst: NOP_INST};
        end else if (load_pipeline) begin
            ifid.pc <= pc;
            ifid.inst <= redirect ? NOP_INST : inst;
        end
    end

    // decode
    control u_control (
        .inst (ifid.inst),
        .cw   (dec_cw)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (memwb.cw.load_regfile && load_pipeline),
        .src_a (dec_cw.src1),
        .src_b (dec_cw.src2),
        .dest  (memwb.cw.dest),
        .in    (wb_value),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            idex <= '{pc: RESET_PC, rs1: '0, rs2: '0, cw: CTRL_BUBBLE};
        else if (load_pipeline)
            idex <= '{pc: ifid.pc, rs1: reg_a, rs2: reg_b,
                      cw: redirect ? CTRL_BUBBLE : dec_cw};
    end

    // execute
    execute_unit u_execute (
        .idex            (idex),
        .alu_out         (alu_out),
        .cmp_bit         (cmp_bit),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            exmem <= '{pc: RESET_PC, alu: '0, rs2: '0, cmp_bit: 1'b0, cw: CTRL_BUBBLE};
        else if (load_pipeline)
            exmem <= '{pc: idex.pc, alu: alu_out, rs2: idex.rs2,
                       cmp_bit: cmp_bit, cw: idex.cw};
    end

    // memory
    load_store_align u_align (
        .store_data      (exmem.rs2),
        .store_funct3    (exmem.cw.funct3),
        .store_offset    (exmem.alu[1:0]),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (store_be),
        .mem_rdata       (mem_rdata),
        .load_funct3     (memwb.cw.funct3),
        .load_offset     (memwb.alu[1:0]),
        .load_value      (load_value)
    );

    assign dread = exmem.cw.mem_read;
    assign dwrite = exmem.cw.mem_write;
    assign mem_byte_enable = exmem.cw.mem_write ? store_be : 4'b0000;
    // idle bus shows the stage pc
    assign mem_address = (dread || dwrite) ? exmem.alu : exmem.pc;

    always_ff @(posedge clk) begin
        if (!rst_n)
            memwb <= '{pc: RESET_PC, alu: '0, cmp_bit: 1'b0, cw: CTRL_BUBBLE};
        else if (load_pipeline)
            memwb <= '{pc: exmem.pc, alu: exmem.alu, cmp_bit: exmem.cmp_bit, cw: exmem.cw};
    end

    // writeback
    always_comb begin
        case (memwb.cw.wbmux_sel)
            wb_alu:      wb_value = memwb.alu;
            wb_cmp:      wb_value = {31'b0, memwb.cmp_bit};
            wb_u_imm:    wb_value = memwb.cw.imm;
            wb_pc_plus4: wb_value = memwb.pc + 32'd4;
            wb_load:     wb_value = load_value;
            default:     wb_value = memwb.alu;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(dread && dwrite))
        else $error("dread and dwrite high together at %h", mem_address);

    assert property (@(posedge clk) disable iff (!rst_n)
        memwb.cw.wbmux_sel inside {wb_alu, wb_cmp, wb_u_imm, wb_pc_plus4, wb_load})
        else $error("illegal writeback select %0d", memwb.cw.wbmux_sel);

    // a bad compare op would silently drop a taken branch
    assert property (@(posedge clk) disable iff (!rst_n)
        idex.cw.cmp_op inside {cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu})
        else $error("illegal compare op %0d", idex.cw.cmp_op);

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import rv32i_pkg::*; (
    input  idex_t     idex,
    output rv32i_word alu_out,
    output logic      cmp_bit,
    output logic      redirect,
    output rv32i_word redirect_target
);

    rv32i_word  opa;
    rv32i_word  opb;
    rv32i_word  cmp_b;
    logic [4:0] shamt;
    logic       is_shift;

    assign opa = (idex.cw.alumux1_sel == alumux1_pc) ? idex.pc : idex.rs1;
    assign opb = (idex.cw.alumux2_sel == alumux2_rs2) ? idex.rs2 : idex.cw.imm;
    assign cmp_b = (idex.cw.cmpmux_sel == cmpmux_imm) ? idex.cw.imm : idex.rs2;
    assign shamt = opb[4:0];
    assign is_shift = idex.cw.alu_op inside {alu_sll, alu_srl, alu_sra};

    always_comb begin
        case (idex.cw.alu_op)
            alu_add:  alu_out = opa + opb;
            alu_sub:  alu_out = opa - opb;
            alu_sll:  alu_out = opa << shamt;
            alu_slt:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
            alu_sltu: alu_out = {31'b0, opa < opb};
            alu_xor:  alu_out = opa ^ opb;
            alu_srl:  alu_out = opa >> shamt;
            alu_sra:  alu_out = $unsigned($signed(opa) >>> shamt);
            alu_or:   alu_out = opa | opb;
            default:  alu_out = opa & opb;
        endcase
    end

    always_comb begin
        case (idex.cw.cmp_op)
            cmp_beq:  cmp_bit = (idex.rs1 == cmp_b);
            cmp_bne:  cmp_bit = (idex.rs1 != cmp_b);
            cmp_blt:  cmp_bit = ($signed(idex.rs1) < $signed(cmp_b));
            cmp_bge:  cmp_bit = ($signed(idex.rs1) >= $signed(cmp_b));
            cmp_bltu: cmp_bit = (idex.rs1 < cmp_b);
            cmp_bgeu: cmp_bit = (idex.rs1 >= cmp_b);
            default:  cmp_bit = 1'b0;
        endcase
    end

    assign redirect = (idex.cw.opcode == op_br && cmp_bit) ||
                      idex.cw.opcode == op_jal ||
                      idex.cw.opcode == op_jalr;
    // jalr drops bit 0 of rs1 + imm
    assign redirect_target = (idex.cw.opcode == op_jalr) ? {alu_out[31:1], 1'b0} : alu_out;

    // decoder must hand over a clean shamt, srai keeps only imm bit 10
    always_comb begin
        if (is_shift && idex.cw.alumux2_sel == alumux2_imm) begin
            assert (idex.cw.imm[31:11] == '0 && idex.cw.imm[9:5] == '0)
                else $error("shift immediate %h has bits above shamt", idex.cw.imm);
        end
    end

endmodule

//--- design/load_store_align.sv
`timescale 1ns/1ps

module load_store_align import rv32i_pkg::*; (
    input  rv32i_word  store_data,
    input  logic [2:0] store_funct3,
    input  logic [1:0] store_offset,
    output rv32i_word  mem_wdata,
    output logic [3:0] mem_byte_enable,
    input  rv32i_word  mem_rdata,
    input  logic [2:0] load_funct3,
    input  logic [1:0] load_offset,
    output rv32i_word  load_value
);

    rv32i_word shifted;

    // store lanes
    always_comb begin
        case (store_funct3[1:0])
            2'b00: begin
                mem_wdata = {4{store_data[7:0]}};
                mem_byte_enable = 4'b0001 << store_offset;
            end
            2'b01: begin
                mem_wdata = {2{store_data[15:0]}};
                mem_byte_enable = 4'b0011 << store_offset;
            end
            default: begin
                mem_wdata = store_data;
                mem_byte_enable = 4'b1111;
            end
        endcase
    end

    assign shifted = mem_rdata >> {load_offset, 3'b000};

    always_comb begin
        case (load_funct3)
            3'b000:  load_value = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  load_value = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  load_value = {24'h0, shifted[7:0]};
            3'b101:  load_value = {16'h0, shifted[15:0]};
            default: load_value = mem_rdata;
        endcase
    end

    // halves must not straddle the word
    always_comb begin
        if (store_funct3[1:0] == 2'b01)
            assert (store_offset != 2'd3) else $error("half store at offset 3");
        if (load_funct3[1:0] == 2'b01)
            assert (load_offset != 2'd3) else $error("half load at offset 3");
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic [4:0] src_a,
    input  logic [4:0] src_b,
    input  logic [4:0] dest,
    input  rv32i_word  in,
    output rv32i_word  reg_a,
    output rv32i_word  reg_b
);

    // x0 has no storage
    rv32i_word regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (load && dest != 5'd0) begin
            regs[dest] <= in;
        end
    end

    // same-cycle write shows up on the read ports
    always_comb begin
        if (src_a == 5'd0)
            reg_a = '0;
        else if (load && src_a == dest)
            reg_a = in;
        else
            reg_a = regs[src_a];

        if (src_b == 5'd0)
            reg_b = '0;
        else if (load && src_b == dest)
            reg_b = in;
        else
            reg_b = regs[src_b];
    end

endmodule

//--- design/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    localparam int NUM_REGS = 32;
    localparam rv32i_word RESET_PC = 32'h0000_0000;
    // addi x0, x0, 0
    localparam rv32i_word NOP_INST = 32'h0000_0013;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {alumux1_rs1, alumux1_pc} alumux1_sel_t;
    typedef enum logic {alumux2_imm, alumux2_rs2} alumux2_sel_t;
    typedef enum logic {cmpmux_rs2, cmpmux_imm} cmpmux_sel_t;

    typedef enum logic [2:0] {
        wb_alu, wb_cmp, wb_u_imm, wb_pc_plus4, wb_load
    } wbmux_sel_t;

    typedef struct packed {
        rv_opcode_t   opcode;
        alu_op_t      alu_op;
        cmp_op_t      cmp_op;
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        cmpmux_sel_t  cmpmux_sel;
        wbmux_sel_t   wbmux_sel;
        // memory access width, word for anything but load/store
        logic [2:0]   funct3;
        logic [4:0]   src1;
        logic [4:0]   src2;
        logic [4:0]   dest;
        logic         load_regfile;
        logic         mem_read;
        logic         mem_write;
        rv32i_word    imm;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_BUBBLE = '{
        opcode:       op_imm,
        alu_op:       alu_add,
        cmp_op:       cmp_beq,
        alumux1_sel:  alumux1_rs1,
        alumux2_sel:  alumux2_imm,
        cmpmux_sel:   cmpmux_rs2,
        wbmux_sel:    wb_alu,
        funct3:       3'b010,
        src1:         5'd0,
        src2:         5'd0,
        dest:         5'd0,
        load_regfile: 1'b0,
        mem_read:     1'b0,
        mem_write:    1'b0,
        imm:          32'h0
    };

    typedef struct packed {
        rv32i_word pc;
        rv32i_word inst;
    } ifid_t;

    typedef struct packed {
        rv32i_word  pc;
        rv32i_word  rs1;
        rv32i_word  rs2;
        ctrl_word_t cw;
    } idex_t;

    typedef struct packed {
        rv32i_word  pc;
        rv32i_word  alu;
        rv32i_word  rs2;
        logic       cmp_bit;
        ctrl_word_t cw;
    } exmem_t;

    typedef struct packed {
        rv32i_word  pc;
        rv32i_word  alu;
        logic       cmp_bit;
        ctrl_word_t cw;
    } memwb_t;

endpackage

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int ROM_WORDS = 256;
localparam int DMEM_WORDS = 256;
// jal x0, 0 sits in the last ROM slot
localparam rv32i_word END_PC = 32'((ROM_WORDS - 1) * 4);
localparam rv32i_word LOOP_INST = 32'h0000_006f;

typedef struct packed {
    rv32i_word  addr;
    rv32i_word  data;
    logic [3:0] be;
} store_rec_t;

rv32i_word  rng_state = 32'd51;
rv32i_word  rom [ROM_WORDS];
rv32i_word  model_mem [DMEM_WORDS];
store_rec_t model_stores [$];

function automatic rv32i_word xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

// odd multiplier, so every word index gives its own pattern
function automatic rv32i_word fill_word(int idx);
    return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
endfunction

// any register except the last three destinations
function automatic logic [4:0] pick_src(logic [14:0] recent);
    logic [4:0] s;
    s = 5'(xorshift());
    while (s != 5'd0 && (s == recent[4:0] || s == recent[9:5] || s == recent[14:10]))
        s = 5'(xorshift());
    return s;
endfunction

function automatic void gen_program();
    bit          reserved [ROM_WORDS];
    logic [14:0] recent;
    logic [20:0] off;
    logic [11:0] imm;
    logic [4:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [1:0]  sz;
    rv32i_word   r;
    int          tgt;
    reserved = '{default: 1'b0};
    recent = '0;
    for (int i = 0; i < ROM_WORDS - 1; i++) begin
        r = xorshift();
        kind = r[4:0];
        f3 = r[10:8];
        rd = 5'(xorshift() % 31) + 5'd1;
        rs1 = pick_src(recent);
        rs2 = pick_src(recent);
        // forward only, target nops stay clear of the final loop
        tgt = i + 1 + int'(r[15:12]);
        if (tgt > ROM_WORDS - 4)
            tgt = ROM_WORDS - 4;
        off = 21'((tgt - i) * 4);
        if (kind >= 5'd26 && kind <= 5'd30 && i > ROM_WORDS - 5)
            kind = 5'd17;
        // 0 byte, 1 half, 2 word
        sz = (r[9:8] == 2'b11) ? 2'b10 : r[9:8];
        imm = {2'b00, r[25:16]} & ~((12'd1 << sz) - 12'd1);
        if (reserved[i]) begin
            rom[i] = NOP_INST;
            rd = 5'd0;
        end else if (kind <= 5'd5) begin
            rom[i] = {imm[11:5], rs2, 5'd0, 1'b0, sz, imm[4:0], 7'b0100011};
            rd = 5'd0;
        end else if (kind <= 5'd10) begin
            f3 = (sz == 2'b10) ? 3'b010 : {r[11], sz};
            rom[i] = {imm, 5'd0, f3, rd, 7'b0000011};
        end else if (kind <= 5'd16) begin
            rom[i] = {(r[11] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000,
                      rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind <= 5'd22 || kind == 5'd31) begin
            if (f3 == 3'b001)
                imm = {7'b0, r[20:16]};
            else if (f3 == 3'b101)
                imm = {1'b0, r[11], 5'b0, r[20:16]};
            else
                imm = r[27:16];
            rom[i] = {imm, rs1, f3, rd, 7'b0010011};
        end else if (kind <= 5'd24) begin
            rom[i] = {r[31:12], rd, 7'b0110111};
        end else if (kind == 5'd25) begin
            rom[i] = {r[31:12], rd, 7'b0010111};
        end else begin
            if (kind <= 5'd28) begin
                f3 = {r[10], r[10] & r[9], r[8]};
                rom[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
                rd = 5'd0;
            end else if (kind == 5'd29) begin
                rom[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            end else begin
                rom[i] = {12'(tgt * 4), 5'd0, 3'b000, rd, 7'b1100111};
            end
            for (int k = 0; k < 3; k++)
                reserved[tgt + k] = 1'b1;
        end
        recent = {recent[9:0], rd};
    end
    rom[ROM_WORDS - 1] = LOOP_INST;
endfunction

function automatic rv32i_word alu_result(logic [2:0] f3, logic alt, rv32i_word a, rv32i_word b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void run_model();
    rv32i_word  regs [32];
    rv32i_word  pc;
    rv32i_word  ins;
    rv32i_word  a;
    rv32i_word  b;
    rv32i_word  imm_i;
    rv32i_word  addr;
    rv32i_word  val;
    rv32i_word  next_pc;
    rv32i_word  word;
    logic [3:0] be;
    logic [2:0] f3;
    bit         wr;
    bit         taken;
    store_rec_t rec;
    for (int k = 0; k < 32; k++)
        regs[k] = '0;
    for (int w = 0; w < DMEM_WORDS; w++)
        model_mem[w] = fill_word(w);
    pc = RESET_PC;
    while (pc != END_PC) begin
        ins = rom[pc[9:2]];
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        val = '0;
        wr = 1'b1;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            7'b0110111: val = {ins[31:12], 12'h000};
            7'b0010111: val = pc + {ins[31:12], 12'h000};
            7'b1101111: begin
                val = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                val = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken)
                    next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'b0000011: begin
                addr = a + imm_i;
                word = model_mem[addr[9:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'b000:  val = {{24{word[7]}}, word[7:0]};
                    3'b001:  val = {{16{word[15]}}, word[15:0]};
                    3'b100:  val = {24'h0, word[7:0]};
                    3'b101:  val = {16'h0, word[15:0]};
                    default: val = model_mem[addr[9:2]];
                endcase
            end
            7'b0100011: begin
                wr = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (f3 == 3'b000)
                    be = 4'b0001 << addr[1:0];
                else if (f3 == 3'b001)
                    be = 4'b0011 << addr[1:0];
                else
                    be = 4'b1111;
                word = (f3 == 3'b010) ? b : b << {addr[1:0], 3'b000};
                for (int k = 0; k < 4; k++)
                    if (be[k])
                        model_mem[addr[9:2]][8*k +: 8] = word[8*k +: 8];
                rec.addr = addr;
                rec.data = word;
                rec.be = be;
                model_stores.push_back(rec);
            end
            7'b0010011: val = alu_result(f3, f3 == 3'b101 && ins[30], a, imm_i);
            7'b0110011: val = alu_result(f3, ins[30], a, b);
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0)
            regs[ins[11:7]] = val;
        pc = next_pc;
    end
endfunction

`endif

//--- tests/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath import rv32i_pkg::*; ();

    logic       clk;
    logic       rst_n;
    logic       load_pipeline;
    rv32i_word  inst;
    rv32i_word  mem_rdata;
    rv32i_word  inst_addr;
    rv32i_word  mem_address;
    rv32i_word  mem_wdata;
    logic [3:0] mem_byte_enable;
    logic       dread;
    logic       dwrite;

    `include "tb_model.svh"

    localparam int MAX_CYCLES = 4 * ROM_WORDS + 40;

    rv32i_word  dmem [DMEM_WORDS];
    rv32i_word  rdata_q;
    int         store_idx;
    int         loop_edges;
    int         cycles;
    int         stall_left;
    bit         count_ok;

    datapath u_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_pipeline   (load_pipeline),
        .inst            (inst),
        .mem_rdata       (mem_rdata),
        .inst_addr       (inst_addr),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .dread           (dread),
        .dwrite          (dwrite)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // combinational instruction ROM
    assign inst = (inst_addr < ROM_WORDS * 4) ? rom[inst_addr[9:2]] : NOP_INST;

    // synchronous data memory that only moves on advancing edges
    always @(posedge clk) begin
        if (rst_n && load_pipeline) begin
            if (dwrite) begin
                for (int k = 0; k < 4; k++)
                    if (mem_byte_enable[k])
                        dmem[mem_address[9:2]][8*k +: 8] <= mem_wdata[8*k +: 8];
            end
            if (dread)
                rdata_q <= dmem[mem_address[9:2]];
        end
    end

    always @(negedge clk) mem_rdata <= rdata_q;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_reset_outputs(input rv32i_word addr, input logic rd, input logic wr,
                                       input logic [3:0] be);
        if (addr !== RESET_PC || rd !== 1'b0 || wr !== 1'b0 || be !== 4'b0000) begin
            $display("[ERROR] inst_addr %h expected %h", addr, RESET_PC);
            $display("[ERROR] dread %h dwrite %h expected 0", rd, wr);
            $display("[ERROR] mem_byte_enable %h expected 0", be);
            abort_run();
        end
    endtask

    task automatic check_store(input store_rec_t exp, input rv32i_word addr,
                               input rv32i_word data, input logic [3:0] be);
        rv32i_word mask;
        bit        bad;
        mask = {{8{exp.be[3]}}, {8{exp.be[2]}}, {8{exp.be[1]}}, {8{exp.be[0]}}};
        bad = 1'b0;
        if (addr !== exp.addr) begin
            $display("[ERROR] store %0d mem_address %h expected %h", store_idx, addr, exp.addr);
            bad = 1'b1;
        end
        if (be !== exp.be) begin
            $display("[ERROR] store %0d mem_byte_enable %h expected %h", store_idx, be, exp.be);
            bad = 1'b1;
        end
        if ((data & mask) !== (exp.data & mask)) begin
            $display("[ERROR] store %0d mem_wdata %h expected %h under mask %h",
                     store_idx, data, exp.data, mask);
            bad = 1'b1;
        end
        if (bad)
            abort_run();
    endtask

    task automatic check_count(input int exp_count, input int got_count, output bit ok);
        ok = (exp_count == got_count);
        if (!ok)
            $display("[ERROR] store count %h expected %h", got_count, exp_count);
    endtask

    // store monitor, timeout and end-of-program detection
    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: final loop not reached within %0d cycles", MAX_CYCLES);
            abort_run();
        end
        if (rst_n && load_pipeline) begin
            if ((dread || dwrite) && mem_address >= DMEM_WORDS * 4) begin
                $display("data access outside the 1 KiB data memory");
                abort_run();
            end
            if (dwrite) begin
                if (store_idx >= model_stores.size()) begin
                    $display("DUT made more stores than the reference model");
                    abort_run();
                end else begin
                    check_store(model_stores[store_idx], mem_address, mem_wdata,
                                mem_byte_enable);
                    store_idx++;
                end
            end
            if (inst_addr == END_PC)
                loop_edges++;
        end
    end

    initial begin
        rst_n = 1'b0;
        load_pipeline = 1'b0;
        mem_rdata = '0;
        rdata_q = '0;
        store_idx = 0;
        loop_edges = 0;
        cycles = 0;
        stall_left = 0;
        gen_program();
        run_model();
        for (int w = 0; w < DMEM_WORDS; w++)
            dmem[w] = fill_word(w);
        $display("program built, %0d stores expected", model_stores.size());

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_outputs(inst_addr, dread, dwrite, mem_byte_enable);

        // a few passes through the final jal drain every older store
        while (loop_edges < 4) begin
            if (stall_left > 0) begin
                load_pipeline = 1'b0;
                stall_left--;
            end else begin
                load_pipeline = 1'b1;
                if ((xorshift() % 8) == 0)
                    stall_left = int'(xorshift() % 4);
            end
            @(negedge clk);
        end

        check_count(model_stores.size(), store_idx, count_ok);
        if (count_ok) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule
